// ==== Bender.yml ====
package:
  name: rvDebugSoc

sources:
  - files:
      - rvPkg.sv
      - controlUnit.sv
      - alu.sv
      - registerUnit.sv
      - cpuCore.sv
      - apbArbiter.sv
      - sharedMemory.sv
      - debugPort.sv
      - rvDebugSoc.sv
  - target: test
    files:
      - tbRvDebugSoc_assert.sv
      - tbChecker.sv
      - tbRvDebugSoc.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [31:0]   a,
  input  logic [31:0]   b,
  input  rvPkg::aluOp_t op,
  output logic [31:0]   result
);

  always_comb begin
    case (op)
      rvPkg::aluAdd: result = a + b;
      rvPkg::aluSub: result = a - b;
      rvPkg::aluAnd: result = a & b;
      rvPkg::aluOr:  result = a | b;
      rvPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
      // Compare results drive the branch decision
      rvPkg::aluEq:  result = {31'b0, a == b};
      rvPkg::aluNe:  result = {31'b0, a != b};
      default:       result = '0;
    endcase
  end

endmodule

// ==== apbArbiter.sv ====
`timescale 1ns/1ps

module apbArbiter (
  input  logic           clk,
  input  logic           rstN,
  input  rvPkg::apbReq_t coreReq,
  input  rvPkg::apbReq_t dbgReq,
  output rvPkg::apbRsp_t coreRsp,
  output rvPkg::apbRsp_t dbgRsp,
  output rvPkg::apbReq_t memReq,
  input  rvPkg::apbRsp_t memRsp
);

  logic busy;
  logic ownerDbg;
  logic lastDbg;
  logic grantDbg;
  logic dbgSel;
  logic xferDone;

  // Round robin, core wins a tie when debug had the last grant
  assign grantDbg = dbgReq.psel && (!coreReq.psel || !lastDbg);
  assign dbgSel   = busy ? ownerDbg : grantDbg;

  // Slave sees a setup cycle first even if the owner already waits in access
  always_comb begin
    memReq         = dbgSel ? dbgReq : coreReq;
    memReq.penable = memReq.penable && busy;
  end

  assign xferDone = busy && memReq.psel && memReq.penable && memRsp.pready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy     <= 1'b0;
      ownerDbg <= 1'b0;
      lastDbg  <= 1'b0;
    end else if (!busy && (coreReq.psel || dbgReq.psel)) begin
      busy     <= 1'b1;
      ownerDbg <= grantDbg;
      lastDbg  <= grantDbg;
    end else if (xferDone) begin
      busy <= 1'b0;
    end
  end

  always_comb begin
    coreRsp.prdata = memRsp.prdata;
    coreRsp.pready = memRsp.pready && busy && !ownerDbg;
    dbgRsp.prdata  = memRsp.prdata;
    dbgRsp.pready  = memRsp.pready && busy && ownerDbg;
  end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
  input  logic [31:0]  instr,
  output rvPkg::ctrl_t ctrl
);

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] iImm;
  logic [31:0] sImm;
  logic [31:0] bImm;
  logic [31:0] jImm;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign iImm = {{20{instr[31]}}, instr[31:20]};
  assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // Unknown encodings fall through as a no-op
    ctrl       = '0;
    ctrl.aluOp = rvPkg::aluAdd;
    ctrl.wbSel = rvPkg::wbAlu;
    case (rvPkg::opcode_t'(instr[6:0]))
      rvPkg::opOp: begin
        ctrl.regWrite = 1'b1;
        case (funct3)
          3'b000:  ctrl.aluOp = funct7[5] ? rvPkg::aluSub : rvPkg::aluAdd;
          3'b010:  ctrl.aluOp = rvPkg::aluSlt;
          3'b110:  ctrl.aluOp = rvPkg::aluOr;
          3'b111:  ctrl.aluOp = rvPkg::aluAnd;
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      rvPkg::opOpImm: begin
        ctrl.regWrite = (funct3 == 3'b000);
        ctrl.aluBSrc  = 1'b1;
        ctrl.imm      = iImm;
      end
      rvPkg::opLoad: begin
        ctrl.regWrite = (funct3 == 3'b010);
        ctrl.memRead  = (funct3 == 3'b010);
        ctrl.aluBSrc  = 1'b1;
        ctrl.wbSel    = rvPkg::wbMem;
        ctrl.imm      = iImm;
      end
      rvPkg::opStore: begin
        ctrl.memWrite = (funct3 == 3'b010);
        ctrl.aluBSrc  = 1'b1;
        ctrl.imm      = sImm;
      end
      rvPkg::opBranch: begin
        ctrl.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
        ctrl.aluOp  = funct3[0] ? rvPkg::aluNe : rvPkg::aluEq;
        ctrl.imm    = bImm;
      end
      rvPkg::opJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.aluASrc  = 1'b1;
        ctrl.aluBSrc  = 1'b1;
        ctrl.wbSel    = rvPkg::wbPc4;
        ctrl.imm      = jImm;
      end
      rvPkg::opSystem: ctrl.ebreak = (instr[31:7] == 25'h0002000);
      default: ctrl.regWrite = 1'b0;
    endcase
  end

endmodule

// ==== cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
  input  logic           clk,
  input  logic           rstN,
  input  logic           run,
  output rvPkg::apbReq_t apbReq,
  input  rvPkg::apbRsp_t apbRsp,
  output logic           halted,
  output logic [31:0]    pc
);

  typedef enum logic [1:0] {sFetch, sExec, sMem, sHalt} state_t;

  state_t       state;
  logic [31:0]  pcQ;
  logic [31:0]  instrQ;
  logic         access;
  rvPkg::ctrl_t ctrl;
  logic [31:0]  rd1;
  logic [31:0]  rd2;
  logic [31:0]  aluA;
  logic [31:0]  aluB;
  logic [31:0]  aluResult;
  logic [31:0]  pcPlus4;
  logic [31:0]  target;
  logic         takeBranch;
  logic         xferDone;
  logic         wrEn;
  logic [31:0]  wrData;

  controlUnit uCtrl (.instr(instrQ), .ctrl(ctrl));

  registerUnit uRegs (
    .clk(clk), .rstN(rstN),
    .rs1(instrQ[19:15]), .rs2(instrQ[24:20]), .rd(instrQ[11:7]),
    .wrData(wrData), .wrEn(wrEn),
    .rd1(rd1), .rd2(rd2)
  );

  assign aluA = ctrl.aluASrc ? pcQ : rd1;
  assign aluB = ctrl.aluBSrc ? ctrl.imm : rd2;

  alu uAlu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult));

  // Separate target adder, ALU only decides taken or not
  assign pcPlus4    = pcQ + 32'd4;
  assign target     = pcQ + ctrl.imm;
  assign takeBranch = ctrl.jump || (ctrl.branch && aluResult[0]);

  always_comb begin
    apbReq = '0;
    if (state == sFetch) begin
      apbReq.psel  = run || access;
      apbReq.paddr = pcQ[rvPkg::addrWidth-1:0];
    end else if (state == sMem) begin
      apbReq.psel   = run || access;
      apbReq.pwrite = ctrl.memWrite;
      apbReq.paddr  = aluResult[rvPkg::addrWidth-1:0];
      apbReq.pwdata = rd2;
    end
    apbReq.penable = access;
  end

  assign xferDone = apbReq.psel && apbReq.penable && apbRsp.pready;

  assign wrEn = ((state == sExec) && ctrl.regWrite && !ctrl.memRead) ||
                ((state == sMem) && ctrl.memRead && xferDone);

  always_comb begin
    case (ctrl.wbSel)
      rvPkg::wbMem: wrData = apbRsp.prdata;
      rvPkg::wbPc4: wrData = pcPlus4;
      default:      wrData = aluResult;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state  <= sFetch;
      pcQ    <= '0;
      access <= 1'b0;
    end else begin
      if (apbReq.psel && !apbReq.penable) begin
        access <= 1'b1;
      end else if (xferDone) begin
        access <= 1'b0;
      end
      case (state)
        sFetch: if (xferDone) state <= sExec;
        sExec: begin
          if (ctrl.ebreak) begin
            state <= sHalt;
          end else if (ctrl.memRead || ctrl.memWrite) begin
            state <= sMem;
          end else begin
            pcQ   <= takeBranch ? target : pcPlus4;
            state <= sFetch;
          end
        end
        sMem: begin
          if (xferDone) begin
            pcQ   <= pcPlus4;
            state <= sFetch;
          end
        end
        default: state <= sHalt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == sFetch) && xferDone) begin
      instrQ <= apbRsp.prdata;
    end
  end

  assign halted = (state == sHalt);
  assign pc     = pcQ;

endmodule

// ==== debugPort.sv ====
`timescale 1ns/1ps

module debugPort (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       dbgValid,
  input  logic                       dbgWrite,
  input  logic [rvPkg::addrWidth-1:0] dbgAddr,
  input  logic [31:0]                dbgWdata,
  output logic                       dbgBusy,
  output logic                       dbgDone,
  output logic [31:0]                dbgRdata,
  output logic [27:0]                hexSeg,
  output rvPkg::apbReq_t             apbReq,
  input  rvPkg::apbRsp_t             apbRsp
);

  typedef enum logic [1:0] {dIdle, dSetup, dAccess} state_t;

  state_t                    state;
  logic [rvPkg::addrWidth-1:0] addrQ;
  logic                      writeQ;
  logic [31:0]               wdataQ;
  logic [31:0]               rdataQ;

  // Active low, segment a in bit 0
  function automatic logic [6:0] segOf(input logic [3:0] nib);
    case (nib)
      4'h0: segOf = 7'b1000000;
      4'h1: segOf = 7'b1111001;
      4'h2: segOf = 7'b0100100;
      4'h3: segOf = 7'b0110000;
      4'h4: segOf = 7'b0011001;
      4'h5: segOf = 7'b0010010;
      4'h6: segOf = 7'b0000010;
      4'h7: segOf = 7'b1111000;
      4'h8: segOf = 7'b0000000;
      4'h9: segOf = 7'b0010000;
      4'hA: segOf = 7'b0001000;
      4'hB: segOf = 7'b0000011;
      4'hC: segOf = 7'b1000110;
      4'hD: segOf = 7'b0100001;
      4'hE: segOf = 7'b0000110;
      default: segOf = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state  <= dIdle;
      rdataQ <= '0;
    end else begin
      case (state)
        dIdle:  if (dbgValid) state <= dSetup;
        dSetup: state <= dAccess;
        dAccess: begin
          if (apbRsp.pready) begin
            state <= dIdle;
            if (!writeQ) rdataQ <= apbRsp.prdata;
          end
        end
        default: state <= dIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == dIdle) && dbgValid) begin
      addrQ  <= dbgAddr;
      writeQ <= dbgWrite;
      wdataQ <= dbgWdata;
    end
  end

  always_comb begin
    apbReq         = '0;
    apbReq.psel    = (state != dIdle);
    apbReq.penable = (state == dAccess);
    apbReq.pwrite  = writeQ;
    apbReq.paddr   = addrQ;
    apbReq.pwdata  = wdataQ;
  end

  assign dbgBusy  = (state != dIdle);
  assign dbgDone  = (state == dAccess) && apbRsp.pready;
  // Fresh read data shows in the completing cycle
  assign dbgRdata = (dbgDone && !writeQ) ? apbRsp.prdata : rdataQ;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      hexSeg[7*i +: 7] = segOf(dbgRdata[4*i +: 4]);
    end
  end

endmodule

// ==== registerUnit.sv ====
`timescale 1ns/1ps

module registerUnit (
  input  logic        clk,
  input  logic        rstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] wrData,
  input  logic        wrEn,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (rd != 5'd0)) begin
      regs[rd] <= wrData;
    end
  end

  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

endmodule

// ==== rvDebugSoc.f ====
rvPkg.sv
controlUnit.sv
alu.sv
registerUnit.sv
cpuCore.sv
apbArbiter.sv
sharedMemory.sv
debugPort.sv
rvDebugSoc.sv
tbRvDebugSoc_assert.sv
tbChecker.sv
tbRvDebugSoc.sv

// ==== rvDebugSoc.sv ====
`timescale 1ns/1ps

module rvDebugSoc (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        run,
  input  logic                        dbgValid,
  input  logic                        dbgWrite,
  input  logic [rvPkg::addrWidth-1:0] dbgAddr,
  input  logic [31:0]                 dbgWdata,
  output logic                        dbgBusy,
  output logic                        dbgDone,
  output logic [31:0]                 dbgRdata,
  output logic [27:0]                 hexSeg,
  output logic                        halted,
  output logic [31:0]                 pc
);

  rvPkg::apbReq_t coreReq;
  rvPkg::apbRsp_t coreRsp;
  rvPkg::apbReq_t dbgApbReq;
  rvPkg::apbRsp_t dbgApbRsp;
  rvPkg::apbReq_t memReq;
  rvPkg::apbRsp_t memRsp;

  cpuCore uCore (
    .clk(clk), .rstN(rstN), .run(run),
    .apbReq(coreReq), .apbRsp(coreRsp),
    .halted(halted), .pc(pc)
  );

  debugPort uDbg (
    .clk(clk), .rstN(rstN),
    .dbgValid(dbgValid), .dbgWrite(dbgWrite), .dbgAddr(dbgAddr), .dbgWdata(dbgWdata),
    .dbgBusy(dbgBusy), .dbgDone(dbgDone), .dbgRdata(dbgRdata), .hexSeg(hexSeg),
    .apbReq(dbgApbReq), .apbRsp(dbgApbRsp)
  );

  apbArbiter uArb (
    .clk(clk), .rstN(rstN),
    .coreReq(coreReq), .dbgReq(dbgApbReq),
    .coreRsp(coreRsp), .dbgRsp(dbgApbRsp),
    .memReq(memReq), .memRsp(memRsp)
  );

  sharedMemory uMem (.clk(clk), .rstN(rstN), .apbReq(memReq), .apbRsp(memRsp));

endmodule

// ==== rvPkg.sv ====
package rvPkg;

  localparam int memWords  = 256;
  localparam int addrWidth = 10;

  // Write-back source select
  localparam logic [1:0] wbAlu = 2'd0;
  localparam logic [1:0] wbMem = 2'd1;
  localparam logic [1:0] wbPc4 = 2'd2;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [addrWidth-1:0] paddr;
    logic [31:0]          pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apbRsp_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluEq,
    aluNe
  } aluOp_t;

  typedef enum logic [6:0] {
    opOp     = 7'b0110011,
    opOpImm  = 7'b0010011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011
  } opcode_t;

  typedef struct packed {
    logic        regWrite;
    logic        aluASrc;
    logic        aluBSrc;
    logic        memRead;
    logic        memWrite;
    logic        branch;
    logic        jump;
    aluOp_t      aluOp;
    logic [1:0]  wbSel;
    logic        ebreak;
    logic [31:0] imm;
  } ctrl_t;

endpackage

// ==== sharedMemory.sv ====
`timescale 1ns/1ps

module sharedMemory (
  input  logic           clk,
  input  logic           rstN,
  input  rvPkg::apbReq_t apbReq,
  output rvPkg::apbRsp_t apbRsp
);

  localparam int idxWidth = $clog2(rvPkg::memWords);

  logic [31:0]         mem [rvPkg::memWords];
  logic [idxWidth-1:0] idx;
  logic                access;

  assign idx    = apbReq.paddr[idxWidth+1:2];
  assign access = apbReq.psel && apbReq.penable;

  // No wait states
  assign apbRsp.pready = access;
  assign apbRsp.prdata = mem[idx];

  // Writes blocked while in reset
  always_ff @(posedge clk) begin
    if (rstN && access && apbReq.pwrite) begin
      mem[idx] <= apbReq.pwdata;
    end
  end

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        run,
  input  logic                        dbgValid,
  input  logic                        dbgWrite,
  input  logic [rvPkg::addrWidth-1:0] dbgAddr,
  input  logic [31:0]                 dbgWdata,
  input  logic                        dbgBusy,
  input  logic                        dbgDone,
  input  logic [31:0]                 dbgRdata,
  input  logic [27:0]                 hexSeg,
  input  logic                        halted,
  input  logic [31:0]                 pc,
  output int                          errors,
  output int                          segErrors,
  output int                          refSteps
);

  typedef logic [31:0] memImg_t [rvPkg::memWords];

  // Active low, gfedcba
  logic [6:0] segTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  memImg_t     shadow;
  memImg_t     finalImg;
  logic        refDone;
  logic        curWrite;
  logic [7:0]  curWord;
  logic        wasHalted;
  logic [31:0] haltPc;
  logic        released;
  int          rstCycles;

  function automatic logic [27:0] segWord(input logic [15:0] v);
    return {segTable[v[15:12]], segTable[v[11:8]], segTable[v[7:4]], segTable[v[3:0]]};
  endfunction

  // Instruction set model over a copy of memory
  function automatic memImg_t refRun(input memImg_t img, output int steps);
    memImg_t     m;
    logic [31:0] x [32];
    logic [31:0] pcM;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] sa;
    logic [31:0] nextPc;
    logic        wr;
    logic        stop;
    m = img;
    foreach (x[i]) x[i] = '0;
    pcM = '0;
    steps = 0;
    stop = 1'b0;
    while (!stop && steps < 10000) begin
      ins = m[pcM[9:2]];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      ea = a + {{20{ins[31]}}, ins[31:20]};
      sa = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      nextPc = pcM + 32'd4;
      res = '0;
      wr = 1'b0;
      steps++;
      case (ins[6:0])
        7'h33: begin
          wr = 1'b1;
          case (ins[14:12])
            3'd0: res = ins[30] ? a - b : a + b;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
        7'h13: begin
          wr = 1'b1;
          res = ea;
        end
        7'h03: begin
          wr = 1'b1;
          res = m[ea[9:2]];
        end
        7'h23: m[sa[9:2]] = b;
        7'h63: begin
          if ((a == b) != ins[12]) begin
            nextPc = pcM + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        7'h6F: begin
          wr = 1'b1;
          res = pcM + 32'd4;
          nextPc = pcM + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h73: stop = 1'b1;
        default: ;
      endcase
      if (wr && (ins[11:7] != 5'd0)) x[ins[11:7]] = res;
      pcM = nextPc;
    end
    return m;
  endfunction

  task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %08h, expected %08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkReset();
    expectEq("halted", halted, 0);
    expectEq("dbgDone", dbgDone, 0);
    expectEq("dbgBusy", dbgBusy, 0);
    if (hexSeg !== segWord(16'h0)) segErrors++;
    expectEq("hexSeg", hexSeg, segWord(16'h0));
  endtask

  task automatic checkRead();
    logic [31:0] expected;
    expected = refDone ? finalImg[curWord] : shadow[curWord];
    expectEq($sformatf("dbgRdata word %0d", curWord), dbgRdata, expected);
    if (hexSeg !== segWord(dbgRdata[15:0])) segErrors++;
    expectEq("hexSeg", hexSeg, segWord(dbgRdata[15:0]));
  endtask

  initial begin
    errors = 0;
    segErrors = 0;
    refSteps = 0;
    refDone = 1'b0;
    curWrite = 1'b1;
    curWord = '0;
    wasHalted = 1'b0;
    haltPc = '0;
    released = 1'b0;
    rstCycles = 0;
    foreach (shadow[i]) shadow[i] = '0;
  end

  always @(posedge clk) begin
    if (!rstN) begin
      // First edge only applies the synchronous reset
      if (rstCycles > 0) checkReset();
      rstCycles++;
    end else begin
      if (!released) begin
        checkReset();
        released = 1'b1;
      end
      if (run && !refDone) begin
        finalImg = refRun(shadow, refSteps);
        refDone = 1'b1;
      end
      if (dbgDone && !curWrite) checkRead();
      if (dbgValid && !dbgBusy) begin
        curWrite = dbgWrite;
        curWord = dbgAddr[9:2];
        if (dbgWrite) shadow[dbgAddr[9:2]] = dbgWdata;
      end
      if (wasHalted && !halted) begin
        $display("Core left the halted state without a reset");
        errors++;
      end else if (wasHalted) begin
        expectEq("pc after halt", pc, haltPc);
      end
      if (halted && !wasHalted) haltPc = pc;
      wasHalted = halted;
    end
  end

endmodule

// ==== tbRvDebugSoc.sv ====
`timescale 1ns/1ps

module tbRvDebugSoc;

  localparam int dataBase    = 128;
  localparam int resultBase  = 160;
  localparam int resultWords = 7;
  localparam int spareWord   = 200;
  localparam int maxRunReads = 40;
  localparam logic [31:0] spareValue = 32'hA5C3_0C8F;

  logic                        clk = 1'b0;
  logic                        rstN;
  logic                        run;
  logic                        dbgValid;
  logic                        dbgWrite;
  logic [rvPkg::addrWidth-1:0] dbgAddr;
  logic [31:0]                 dbgWdata;
  logic                        dbgBusy;
  logic                        dbgDone;
  logic [31:0]                 dbgRdata;
  logic [27:0]                 hexSeg;
  logic                        halted;
  logic [31:0]                 pc;
  int                          errors;
  int                          segErrors;
  int                          refSteps;
  int                          tbErrors;
  int                          lastErrors;
  int                          numXfers;
  int                          runReads;
  logic [31:0]                 prog [$];
  logic [31:0]                 data [8];

  always #5 clk = ~clk;

  rvDebugSoc DUT (
    .clk(clk), .rstN(rstN), .run(run),
    .dbgValid(dbgValid), .dbgWrite(dbgWrite), .dbgAddr(dbgAddr), .dbgWdata(dbgWdata),
    .dbgBusy(dbgBusy), .dbgDone(dbgDone), .dbgRdata(dbgRdata), .hexSeg(hexSeg),
    .halted(halted), .pc(pc)
  );

  tbChecker uChecker (
    .clk(clk), .rstN(rstN), .run(run),
    .dbgValid(dbgValid), .dbgWrite(dbgWrite), .dbgAddr(dbgAddr), .dbgWdata(dbgWdata),
    .dbgBusy(dbgBusy), .dbgDone(dbgDone), .dbgRdata(dbgRdata), .hexSeg(hexSeg),
    .halted(halted), .pc(pc),
    .errors(errors), .segErrors(segErrors), .refSteps(refSteps)
  );

  // RV32I encoders
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic buildProgram();
    // Sum of eight words at byte 512
    prog.push_back(addi(1, 0, 512));
    prog.push_back(addi(2, 0, 8));
    prog.push_back(addi(3, 0, 0));
    prog.push_back(lw(4, 1, 0));
    prog.push_back(rOp(7'h00, 3'd0, 3, 3, 4));
    prog.push_back(addi(1, 1, 4));
    prog.push_back(addi(2, 2, -1));
    prog.push_back(branch(3'd1, 2, 0, -16));
    prog.push_back(jal(5, 40));
    // Results at byte 640
    prog.push_back(addi(6, 0, 640));
    prog.push_back(sw(3, 6, 0));
    prog.push_back(sw(7, 6, 4));
    prog.push_back(sw(8, 6, 8));
    prog.push_back(sw(9, 6, 12));
    prog.push_back(sw(10, 6, 16));
    prog.push_back(sw(5, 6, 20));
    prog.push_back(sw(11, 6, 24));
    prog.push_back(32'h0010_0073);
    // Subroutine at byte 72
    prog.push_back(lw(12, 1, -32));
    prog.push_back(lw(13, 1, -28));
    prog.push_back(rOp(7'h20, 3'd0, 7, 3, 12));
    prog.push_back(rOp(7'h00, 3'd7, 8, 12, 13));
    prog.push_back(rOp(7'h00, 3'd6, 9, 12, 13));
    prog.push_back(rOp(7'h00, 3'd2, 10, 12, 13));
    prog.push_back(addi(11, 0, 1));
    prog.push_back(branch(3'd0, 10, 10, 8));
    prog.push_back(addi(11, 0, 99));
    prog.push_back(branch(3'd0, 12, 13, 8));
    prog.push_back(addi(11, 11, 2));
    prog.push_back(jal(0, -80));
  endtask

  task automatic debugXfer(input logic write, input int addr, input logic [31:0] wdata);
    int waitCycles;
    waitCycles = 0;
    while (dbgBusy) @(negedge clk);
    dbgValid = 1'b1;
    dbgWrite = write;
    dbgAddr  = addr[rvPkg::addrWidth-1:0];
    dbgWdata = wdata;
    @(negedge clk);
    dbgValid = 1'b0;
    while (!dbgDone && waitCycles < 200) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!dbgDone) begin
      $display("Debug transfer to byte address %03h never completed", addr);
      tbErrors++;
    end
  endtask

  task automatic waitHalt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < 50 * refSteps + 100) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("Core did not halt within %0d cycles", cycles);
      tbErrors++;
    end
  endtask

  task automatic endTest(input string name);
    int total;
    total = errors + tbErrors;
    if (total == lastErrors) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, total - lastErrors);
    lastErrors = total;
  endtask

  initial begin
    rstN = 1'b0;
    run = 1'b0;
    dbgValid = 1'b0;
    dbgWrite = 1'b0;
    dbgAddr = '0;
    dbgWdata = '0;
    tbErrors = 0;
    lastErrors = 0;
    runReads = 0;
    void'($urandom(37));
    foreach (data[i]) data[i] = $urandom;
    buildProgram();
    numXfers = 2 * (prog.size() + 9) + maxRunReads + resultWords;

    repeat (10) @(negedge clk);
    rstN = 1'b1;
    repeat (2) @(negedge clk);
    endTest("reset state");

    foreach (prog[i]) debugXfer(1'b1, 4 * i, prog[i]);
    foreach (data[i]) debugXfer(1'b1, 4 * (dataBase + i), data[i]);
    debugXfer(1'b1, 4 * spareWord, spareValue);
    foreach (prog[i]) debugXfer(1'b0, 4 * i, '0);
    foreach (data[i]) debugXfer(1'b0, 4 * (dataBase + i), '0);
    debugXfer(1'b0, 4 * spareWord, '0);
    endTest("debug load and readback");

    run = 1'b1;
    while (!halted && runReads < maxRunReads) begin
      debugXfer(1'b0, 4 * spareWord, '0);
      runReads++;
    end
    endTest("debug reads while core runs");

    waitHalt();
    repeat (20) @(negedge clk);
    endTest("core runs to halt");

    for (int i = 0; i < resultWords; i++) begin
      debugXfer(1'b0, 4 * (resultBase + i), '0);
    end
    endTest("results against reference");

    $display("Test segment display: %0d mismatches", segErrors);
    $display("Tests run: 6, errors: %0d", errors + tbErrors);
    if (errors + tbErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Limit grows once the reference step count is known
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 200 * numXfers + 50 * refSteps + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles without finishing", cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== tbRvDebugSoc_assert.sv ====
`timescale 1ns/1ps

module tbRvDebugSoc_assert (
  input logic           clk,
  input logic           rstN,
  input rvPkg::apbReq_t coreReq,
  input rvPkg::apbReq_t dbgReq,
  input rvPkg::apbRsp_t coreRsp,
  input rvPkg::apbRsp_t dbgRsp,
  input rvPkg::apbReq_t memReq
);

  corePenable: assert property (@(posedge clk) disable iff (!rstN)
    coreReq.penable |-> coreReq.psel)
    else $error("core penable high without psel");

  dbgPenable: assert property (@(posedge clk) disable iff (!rstN)
    dbgReq.penable |-> dbgReq.psel)
    else $error("debug penable high without psel");

  memPenable: assert property (@(posedge clk) disable iff (!rstN)
    memReq.penable |-> memReq.psel)
    else $error("memory penable high without psel");

  // Held until the master's own pready
  coreStable: assert property (@(posedge clk) disable iff (!rstN)
    (coreReq.psel && !coreRsp.pready) |=>
      coreReq.psel && $stable({coreReq.pwrite, coreReq.paddr, coreReq.pwdata}))
    else $error("core request changed before pready");

  dbgStable: assert property (@(posedge clk) disable iff (!rstN)
    (dbgReq.psel && !dbgRsp.pready) |=>
      dbgReq.psel && $stable({dbgReq.pwrite, dbgReq.paddr, dbgReq.pwdata}))
    else $error("debug request changed before pready");

  // A master sees pready only while its own request reaches the memory
  coreReady: assert property (@(posedge clk) disable iff (!rstN)
    coreRsp.pready |-> (memReq == coreReq) && !dbgRsp.pready)
    else $error("core given pready for a transfer it does not own");

  dbgReady: assert property (@(posedge clk) disable iff (!rstN)
    dbgRsp.pready |-> (memReq == dbgReq) && !coreRsp.pready)
    else $error("debug given pready for a transfer it does not own");

endmodule

bind apbArbiter tbRvDebugSoc_assert uApbAssert (
  .clk(clk), .rstN(rstN),
  .coreReq(coreReq), .dbgReq(dbgReq),
  .coreRsp(coreRsp), .dbgRsp(dbgRsp),
  .memReq(memReq)
);
